//--- Bender.yml
package:
  name: lc3b_exec_slice

sources:
  - files:
      - design/lc3b_types.sv
      - design/gen_control.sv
      - design/regfile.sv
      - design/alu.sv
      - design/execute_stage.sv
      - design/lc3b_exec_slice.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/lc3b_exec_slice_tb.sv

//--- design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  lc3b_types::lc3b_aluop aluop,
	input  lc3b_types::lc3b_word  a,
	input  lc3b_types::lc3b_word  b,
	output lc3b_types::lc3b_word  f
);

	import lc3b_types::*;

	logic [3:0] shamt;

	// Only the low four bits of b count as a shift amount.
	assign shamt = b[3:0];

	always_comb begin
		case (aluop)
			alu_add:  f = a + b;
			alu_and:  f = a & b;
			alu_not:  f = ~a;
			alu_pass: f = a;
			alu_sll:  f = a << shamt;
			alu_srl:  f = a >> shamt;
			// Sign bit is copied into the vacated positions.
			alu_sra:  f = lc3b_word'($signed(a) >>> shamt);
			default:  f = a;
		endcase
	end

endmodule : alu

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  lc3b_types::lc3b_aluop  aluop,
	input  lc3b_types::lc3b_alumux alumux_sel,
	input  lc3b_types::lc3b_wbmux  wbmux_sel,
	input  logic                   regfile_load,
	input  logic                   cc_load,
	input  lc3b_types::lc3b_reg    sr1,
	input  lc3b_types::lc3b_reg    sr2,
	input  lc3b_types::lc3b_word   sr1_data,
	input  lc3b_types::lc3b_word   sr2_data,
	input  logic [4:0]             imm5,
	input  logic [3:0]             imm4,
	input  lc3b_types::lc3b_word   lea_addr,
	input  lc3b_types::lc3b_reg    dest,
	output logic                   out_valid,
	output logic                   out_load,
	output logic                   out_cc_load,
	output lc3b_types::lc3b_reg    out_dest,
	output lc3b_types::lc3b_word   out_data
);

	import lc3b_types::*;

	logic     fwd_ok;
	lc3b_word op_a;
	lc3b_word op_r2;
	lc3b_word op_b;
	lc3b_word alu_f;
	lc3b_word result;

	// The instruction one ahead sits in our own output register.
	// Its result is taken over the stale register file value.
	assign fwd_ok = out_valid && out_load;
	assign op_a   = (fwd_ok && (out_dest == sr1)) ? out_data : sr1_data;
	assign op_r2  = (fwd_ok && (out_dest == sr2)) ? out_data : sr2_data;

	always_comb begin
		case (alumux_sel)
			alumux_imm5: op_b = {{11{imm5[4]}}, imm5};
			alumux_imm4: op_b = {12'h000, imm4};
			default:     op_b = op_r2;
		endcase
	end

	alu u_alu (
		.aluop (aluop),
		.a     (op_a),
		.b     (op_b),
		.f     (alu_f)
	);

	assign result = (wbmux_sel == wbmux_lea) ? lea_addr : alu_f;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid   <= 1'b0;
			out_load    <= 1'b0;
			out_cc_load <= 1'b0;
			out_dest    <= '0;
			out_data    <= '0;
		end else begin
			out_valid   <= in_valid;
			out_load    <= regfile_load;
			out_cc_load <= cc_load;
			out_dest    <= dest;
			out_data    <= result;
		end
	end

endmodule : execute_stage

`default_nettype wire

//--- design/gen_control.sv
`timescale 1ns/10ps
`default_nettype none

module gen_control (
	input  lc3b_types::lc3b_opcode opcode,
	input  logic [10:0]            ir_bits,
	output lc3b_types::lc3b_aluop  aluop,
	output lc3b_types::lc3b_alumux alumux_sel,
	output lc3b_types::lc3b_wbmux  wbmux_sel,
	output logic                   regfile_load,
	output logic                   cc_load
);

	import lc3b_types::*;

	always_comb begin
		// Every opcode starts out as an add that writes nothing.
		aluop        = alu_add;
		alumux_sel   = alumux_sr2;
		wbmux_sel    = wbmux_alu;
		regfile_load = 1'b0;
		cc_load      = 1'b0;

		case (opcode)
			op_add: begin
				// Bit 5 set means the imm5 form.
				if (ir_bits[5]) begin
					alumux_sel = alumux_imm5;
				end
				regfile_load = 1'b1;
				cc_load      = 1'b1;
			end
			op_and: begin
				if (ir_bits[5]) begin
					alumux_sel = alumux_imm5;
				end
				aluop        = alu_and;
				regfile_load = 1'b1;
				cc_load      = 1'b1;
			end
			op_not: begin
				aluop        = alu_not;
				regfile_load = 1'b1;
				cc_load      = 1'b1;
			end
			op_shf: begin
				// Bit 4 picks the direction, bit 5 the arithmetic form of a right shift.
				alumux_sel = alumux_imm4;
				if (!ir_bits[4]) begin
					aluop = alu_sll;
				end else if (!ir_bits[5]) begin
					aluop = alu_srl;
				end else begin
					aluop = alu_sra;
				end
				regfile_load = 1'b1;
				cc_load      = 1'b1;
			end
			op_lea: begin
				wbmux_sel    = wbmux_lea;
				regfile_load = 1'b1;
				cc_load      = 1'b1;
			end
			// Memory, control flow and trap opcodes have no effect in this slice.
			op_br, op_jmp, op_jsr, op_ldb, op_ldi, op_ldr,
			op_rti, op_stb, op_sti, op_str, op_trap: begin
			end
			default: begin
			end
		endcase
	end

endmodule : gen_control

`default_nettype wire

//--- design/lc3b_exec_slice.sv
`timescale 1ns/10ps
`default_nettype none

module lc3b_exec_slice (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  lc3b_types::lc3b_word instr,
	input  lc3b_types::lc3b_word pc,
	output logic                 wb_valid,
	output lc3b_types::lc3b_reg  wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output lc3b_types::lc3b_nzp  cc
);

	import lc3b_types::*;

	// Decode stage signals.
	lc3b_opcode opcode;
	lc3b_aluop  dec_aluop;
	lc3b_alumux dec_alumux_sel;
	lc3b_wbmux  dec_wbmux_sel;
	logic       dec_regfile_load;
	logic       dec_cc_load;
	lc3b_word   rf_sr1_data;
	lc3b_word   rf_sr2_data;
	lc3b_word   dec_lea_addr;

	// Decode/execute registers.
	logic       de_valid;
	lc3b_aluop  de_aluop;
	lc3b_alumux de_alumux_sel;
	lc3b_wbmux  de_wbmux_sel;
	logic       de_regfile_load;
	logic       de_cc_load;
	lc3b_reg    de_sr1;
	lc3b_reg    de_sr2;
	lc3b_word   de_sr1_data;
	lc3b_word   de_sr2_data;
	logic [4:0] de_imm5;
	logic [3:0] de_imm4;
	lc3b_word   de_lea_addr;
	lc3b_reg    de_dest;

	// Execute/writeback register outputs.
	logic       ex_valid;
	logic       ex_load;
	logic       ex_cc_load;
	lc3b_reg    ex_dest;
	lc3b_word   ex_data;
	lc3b_nzp    wb_nzp;

	assign opcode = lc3b_opcode'(instr[15:12]);

	gen_control u_gen_control (
		.opcode       (opcode),
		.ir_bits      (instr[10:0]),
		.aluop        (dec_aluop),
		.alumux_sel   (dec_alumux_sel),
		.wbmux_sel    (dec_wbmux_sel),
		.regfile_load (dec_regfile_load),
		.cc_load      (dec_cc_load)
	);

	// The write port is driven straight from the execute/writeback register.
	regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (wb_valid),
		.dest     (ex_dest),
		.wdata    (ex_data),
		.sr1      (instr[8:6]),
		.sr2      (instr[2:0]),
		.sr1_data (rf_sr1_data),
		.sr2_data (rf_sr2_data)
	);

	// PC plus offset9 in words, turned into a byte address.
	assign dec_lea_addr = pc + {{6{instr[8]}}, instr[8:0], 1'b0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			de_valid        <= 1'b0;
			de_aluop        <= alu_add;
			de_alumux_sel   <= alumux_sr2;
			de_wbmux_sel    <= wbmux_alu;
			de_regfile_load <= 1'b0;
			de_cc_load      <= 1'b0;
			de_sr1          <= '0;
			de_sr2          <= '0;
			de_sr1_data     <= '0;
			de_sr2_data     <= '0;
			de_imm5         <= '0;
			de_imm4         <= '0;
			de_lea_addr     <= '0;
			de_dest         <= '0;
		end else begin
			de_valid        <= instr_valid;
			de_aluop        <= dec_aluop;
			de_alumux_sel   <= dec_alumux_sel;
			de_wbmux_sel    <= dec_wbmux_sel;
			de_regfile_load <= dec_regfile_load;
			de_cc_load      <= dec_cc_load;
			de_sr1          <= instr[8:6];
			de_sr2          <= instr[2:0];
			de_sr1_data     <= rf_sr1_data;
			de_sr2_data     <= rf_sr2_data;
			de_imm5         <= instr[4:0];
			de_imm4         <= instr[3:0];
			de_lea_addr     <= dec_lea_addr;
			de_dest         <= instr[11:9];
		end
	end

	execute_stage u_execute_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (de_valid),
		.aluop        (de_aluop),
		.alumux_sel   (de_alumux_sel),
		.wbmux_sel    (de_wbmux_sel),
		.regfile_load (de_regfile_load),
		.cc_load      (de_cc_load),
		.sr1          (de_sr1),
		.sr2          (de_sr2),
		.sr1_data     (de_sr1_data),
		.sr2_data     (de_sr2_data),
		.imm5         (de_imm5),
		.imm4         (de_imm4),
		.lea_addr     (de_lea_addr),
		.dest         (de_dest),
		.out_valid    (ex_valid),
		.out_load     (ex_load),
		.out_cc_load  (ex_cc_load),
		.out_dest     (ex_dest),
		.out_data     (ex_data)
	);

	assign wb_valid = ex_valid && ex_load;
	assign wb_dest  = ex_dest;
	assign wb_data  = ex_data;

	always_comb begin
		if (ex_data[15]) begin
			wb_nzp = 3'b100;
		end else if (ex_data == '0) begin
			wb_nzp = 3'b010;
		end else begin
			wb_nzp = 3'b001;
		end
	end

	// Codes come out of reset as zero.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cc <= 3'b010;
		end else if (ex_valid && ex_cc_load) begin
			cc <= wb_nzp;
		end
	end

endmodule : lc3b_exec_slice

`default_nettype wire

//--- design/lc3b_types.sv
`default_nettype none

package lc3b_types;

	// One data word of the machine.
	typedef logic [15:0] lc3b_word;

	// Index of one of the eight general purpose registers.
	typedef logic [2:0] lc3b_reg;

	// Condition codes, ordered as negative, zero, positive.
	typedef logic [2:0] lc3b_nzp;

	// Opcodes as they appear in bits 15:12 of the instruction word.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Operations the ALU can perform.
	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// Source of the second ALU operand.
	typedef enum logic [1:0] {
		alumux_sr2,
		alumux_imm5,
		alumux_imm4
	} lc3b_alumux;

	// Source of the value written back to the register file.
	typedef enum logic {
		wbmux_alu,
		wbmux_lea
	} lc3b_wbmux;

endpackage : lc3b_types

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  lc3b_types::lc3b_reg  dest,
	input  lc3b_types::lc3b_word wdata,
	input  lc3b_types::lc3b_reg  sr1,
	input  lc3b_types::lc3b_reg  sr2,
	output lc3b_types::lc3b_word sr1_data,
	output lc3b_types::lc3b_word sr2_data
);

	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= wdata;
		end
	end

	// A read of the register being written sees the new value in the same cycle.
	assign sr1_data = (load && (dest == sr1)) ? wdata : regs[sr1];
	assign sr2_data = (load && (dest == sr2)) ? wdata : regs[sr2];

endmodule : regfile

`default_nettype wire

//--- lc3b_exec_slice.f
+incdir+tb
design/lc3b_types.sv
design/gen_control.sv
design/regfile.sv
design/alu.sv
design/execute_stage.sv
design/lc3b_exec_slice.sv
tb/lc3b_exec_slice_tb.sv

//--- tb/lc3b_ref_model.svh
// Architectural state of the reference model, updated in issue order.
logic [15:0] arch_regs [8];
logic [2:0]  arch_cc;

function automatic void reset_model();
	for (int i = 0; i < 8; i++) begin
		arch_regs[i] = 16'h0000;
	end
	arch_cc = 3'b010;
endfunction

// Only ADD, AND, NOT, SHF and LEA write a register in this slice.
function automatic bit writes_register(input logic [15:0] ir);
	case (ir[15:12])
		4'h1, 4'h5, 4'h9, 4'hd, 4'he: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [2:0] nzp_of(input logic [15:0] value);
	if (value[15]) begin
		return 3'b100;
	end else if (value == 16'h0000) begin
		return 3'b010;
	end
	return 3'b001;
endfunction

function automatic logic [15:0] compute_result(input logic [15:0] ir,
		input logic [15:0] pc_val);
	logic [15:0] a;
	logic [15:0] b;
	logic [3:0]  n;
	a = arch_regs[ir[8:6]];
	b = ir[5] ? 16'($signed(ir[4:0])) : arch_regs[ir[2:0]];
	n = ir[3:0];
	case (ir[15:12])
		4'h1: return a + b;
		4'h5: return a & b;
		4'h9: return ~a;
		4'hd: begin
			if (!ir[4]) begin
				return a << n;
			end else if (!ir[5]) begin
				return a >> n;
			end
			// Fill the upper bits with ones when the operand is negative.
			return (a >> n) | (a[15] ? ~(16'hffff >> n) : 16'h0000);
		end
		// The word offset counts two bytes per step.
		4'he: return pc_val + 16'($signed(ir[8:0]) * 2);
		default: return a;
	endcase
endfunction

// Applies one instruction to the model and reports whether it writes a register.
function automatic bit apply_instruction(input logic [15:0] ir, input logic [15:0] pc_val,
		output logic [15:0] result);
	result = 16'h0000;
	if (!writes_register(ir)) begin
		return 1'b0;
	end
	result = compute_result(ir, pc_val);
	arch_regs[ir[11:9]] = result;
	arch_cc = nzp_of(result);
	return 1'b1;
endfunction

//--- tb/lc3b_exec_slice_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lc3b_exec_slice_tb;

	localparam int num_instr   = 400;
	localparam int cycle_limit = 16 + 3 * num_instr + 50;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instr;
	logic [15:0] pc;
	logic        wb_valid;
	logic [2:0]  wb_dest;
	logic [15:0] wb_data;
	logic [2:0]  cc;

	int cycle_count = 0;

	// Expected outputs per issue slot, in issue order.
	bit          wr_q [$];
	logic [2:0]  dest_q [$];
	logic [15:0] data_q [$];
	logic [2:0]  cc_q [$];

	`include "lc3b_ref_model.svh"

	lc3b_exec_slice DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_dest     (wb_dest),
		.wb_data     (wb_data),
		.cc          (cc)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Writeback shows the slot issued two cycles ago, cc the one issued three cycles ago.
	task automatic compare_outputs();
		bit          exp_wr;
		logic [2:0]  exp_dest;
		logic [15:0] exp_data;
		exp_wr   = wr_q.pop_front();
		exp_dest = dest_q.pop_front();
		exp_data = data_q.pop_front();
		check_value("wb_valid", {15'h0000, exp_wr}, {15'h0000, wb_valid});
		if (exp_wr) begin
			check_value("wb_dest", {13'h0000, exp_dest}, {13'h0000, wb_dest});
			check_value("wb_data", exp_data, wb_data);
		end
		check_value("cc", {13'h0000, cc_q.pop_front()}, {13'h0000, cc});
	endtask

	task automatic issue_slot(input bit valid, input logic [15:0] ir, input logic [15:0] pc_val);
		bit          wr;
		logic [15:0] res;
		wr  = 1'b0;
		res = 16'h0000;
		if (valid) begin
			wr = apply_instruction(ir, pc_val, res);
		end
		wr_q.push_back(wr);
		dest_q.push_back(ir[11:9]);
		data_q.push_back(res);
		cc_q.push_back(arch_cc);
		instr_valid = valid;
		instr       = ir;
		pc          = pc_val;
	endtask

	initial begin
		int unsigned seed;
		int unsigned rnd;
		int          issued;
		int          slot;
		int          mode;
		bit          valid;
		logic [15:0] ir;
		logic [15:0] pc_val;
		logic [2:0]  last_dest;
		logic [2:0]  prev_dest;
		seed = 81477;
		void'($urandom(seed));
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = 16'h0000;
		pc          = 16'h0000;
		issued      = 0;
		slot        = 0;
		mode        = 0;
		last_dest   = 3'd0;
		prev_dest   = 3'd0;
		reset_model();

		repeat (16) begin
			@(negedge clk);
			check_value("wb_valid", 16'h0000, {15'h0000, wb_valid});
			check_value("cc", 16'h0002, {13'h0000, cc});
		end
		rst_n = 1'b1;

		// Slots before the first issue write nothing and leave cc at Z.
		repeat (2) begin
			wr_q.push_back(1'b0);
			dest_q.push_back(3'd0);
			data_q.push_back(16'h0000);
		end
		repeat (3) cc_q.push_back(3'b010);

		while (issued < num_instr) begin
			@(negedge clk);
			compare_outputs();
			// The strobe density changes every 40 cycles: back to back, half, or a third.
			if (slot % 40 == 0) begin
				mode = $urandom % 3;
			end
			case (mode)
				0: valid = 1'b1;
				1: valid = ($urandom % 2) == 0;
				default: valid = ($urandom % 3) == 0;
			endcase
			rnd    = $urandom;
			ir     = rnd[15:0];
			rnd    = $urandom;
			pc_val = {rnd[15:1], 1'b0};
			// Point sources at recent destinations to exercise the hazard paths.
			rnd = $urandom;
			if (rnd[0]) begin
				ir[8:6] = last_dest;
			end
			if (rnd[1]) begin
				ir[2:0] = rnd[2] ? last_dest : prev_dest;
			end
			issue_slot(valid, ir, pc_val);
			if (valid) begin
				prev_dest = last_dest;
				last_dest = ir[11:9];
				issued++;
			end
			slot++;
		end

		repeat (3) begin
			@(negedge clk);
			compare_outputs();
			issue_slot(1'b0, 16'h0000, 16'h0000);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
